// File: verilog/vp_timing_pkg.sv
`default_nettype none

package vp_timing_pkg;

    // Input frame, active region only
    localparam int H_DISP    = 12;
    localparam int V_DISP    = 6;

    // Crop window, start inclusive and end exclusive
    localparam int START_X   = 2;
    localparam int END_X     = 10;
    localparam int START_Y   = 1;
    localparam int END_Y     = 5;
    localparam int CROP_W    = END_X - START_X;     // Stored pixels per line

    // Output line after 2x upscale and padding
    localparam int OUT_H     = 20;
    localparam int PAD_N     = OUT_H - 2 * CROP_W;  // Black pixels per line

    // Derived widths
    localparam int X_W       = 4;                   // x and y counters
    localparam int ADDR_W    = 4;                   // Bank bit and column
    localparam int COL_W     = ADDR_W - 1;
    localparam int RAM_DEPTH = 1 << ADDR_W;
    localparam int OUT_CNT_W = $clog2(OUT_H);       // Output pixel counter

endpackage

`default_nettype wire

// File: verilog/vp_pixel_pkg.sv
`default_nettype none

package vp_pixel_pkg;

    // External pixel format, r5 g6 b5
    typedef logic [15:0] rgb565_t;

    // Internal pixel, one byte per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    localparam rgb888_t FILL_PIXEL = '0;  // Black

    // Who holds the line memory port in a given cycle
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_WRITER,
        OWN_READER
    } arb_owner_e;

    // Replay passes over one stored line
    typedef enum logic [1:0] {
        RP_IDLE,
        RP_PASS0,   // First copy of the line
        RP_PASS1    // Repeated copy
    } replay_state_e;

endpackage

`default_nettype wire

// File: verilog/line_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// One requester's path to the shared line memory
interface line_mem_if;
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    logic              req;     // Access request
    logic              we;      // 1 = write, 0 = read
    logic [ADDR_W-1:0] addr;    // {bank, column}
    rgb888_t           wdata;
    logic              gnt;     // Access taken this cycle
    rgb888_t           rdata;
    logic              rvalid;  // Read data valid, one cycle after gnt

    // Block that wants the memory
    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    // Side facing the arbiter
    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

// File: verilog/video_crop.sv
`timescale 1ns/1ps
`default_nettype none

module video_crop (
    input  wire                         clk_vpm,
    input  wire                         arst_n_i,
    input  wire                         vs_i,
    input  wire                         de_i,
    input  wire vp_pixel_pkg::rgb565_t  data_i,
    line_mem_if.requester               mem,
    output logic                        line_done_o,
    output logic                        bank_o
);
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    logic [X_W-1:0]    x_q;
    logic [X_W-1:0]    y_q;
    logic              bank_q;      // Bank being filled
    logic              in_win;
    logic              row_end;     // Last window pixel of a row
    logic [COL_W-1:0]  col;
    rgb888_t           pix_wide;
    logic              req_q;
    logic [ADDR_W-1:0] addr_q;
    rgb888_t           wdata_q;

    assign in_win  = de_i && (x_q >= X_W'(START_X)) && (x_q < X_W'(END_X))
                          && (y_q >= X_W'(START_Y)) && (y_q < X_W'(END_Y));
    assign row_end = in_win && (x_q == X_W'(END_X - 1));
    assign col     = COL_W'(x_q - X_W'(START_X));

    // Zero pad the low bits of each channel
    assign pix_wide = {data_i[15:11], 3'b000, data_i[10:5], 2'b00, data_i[4:0], 3'b000};

    // --------------------------------------------------
    // Position in the input frame
    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (vs_i) begin  // New frame
            x_q <= '0;
            y_q <= '0;
        end else if (de_i) begin
            if (x_q == X_W'(H_DISP - 1)) begin
                x_q <= '0;
                if (y_q != X_W'(V_DISP)) y_q <= y_q + 1'b1;  // Hold past frame end
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Write request and line handover
    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q       <= 1'b0;
            line_done_o <= 1'b0;
            bank_q      <= 1'b0;
            bank_o      <= 1'b0;
        end else begin
            req_q       <= in_win;   // One write per window pixel
            line_done_o <= row_end;  // Same cycle as the last write
            if (row_end) begin
                bank_o <= bank_q;    // Finished bank goes to replay
                bank_q <= ~bank_q;   // Ping-pong
            end
        end
    end

    always_ff @(posedge clk_vpm) begin
        if (in_win) begin
            addr_q  <= {bank_q, col};
            wdata_q <= pix_wide;
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = 1'b1;  // Write only
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                                 clk_vpm,
    input  wire                                 arst_n_i,
    line_mem_if.arbiter                         wr,
    line_mem_if.arbiter                         rd,
    output logic                                ram_en_o,
    output logic                                ram_we_o,
    output logic [vp_timing_pkg::ADDR_W-1:0]    ram_addr_o,
    output vp_pixel_pkg::rgb888_t               ram_wdata_o,
    input  wire vp_pixel_pkg::rgb888_t          ram_rdata_i
);
    import vp_pixel_pkg::*;

    arb_owner_e owner;       // Port owner this cycle
    arb_owner_e rsp_owner_q; // Owner of the read in flight

    // Writer has fixed priority
    always_comb begin
        owner = OWN_NONE;
        if (wr.req)      owner = OWN_WRITER;
        else if (rd.req) owner = OWN_READER;
    end

    assign wr.gnt = (owner == OWN_WRITER);
    assign rd.gnt = (owner == OWN_READER);

    // RAM port mux
    always_comb begin
        ram_en_o    = 1'b0;
        ram_we_o    = 1'b0;
        ram_addr_o  = rd.addr;
        ram_wdata_o = rd.wdata;
        case (owner)
            OWN_WRITER: begin
                ram_en_o    = 1'b1;
                ram_we_o    = wr.we;
                ram_addr_o  = wr.addr;
                ram_wdata_o = wr.wdata;
            end
            OWN_READER: begin
                ram_en_o = 1'b1;
                ram_we_o = rd.we;
            end
            default: ;
        endcase
    end

    // RAM read is registered, so read valid follows the grant by one cycle
    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) rsp_owner_q <= OWN_NONE;
        else           rsp_owner_q <= (ram_en_o && !ram_we_o) ? owner : OWN_NONE;
    end

    assign wr.rdata  = ram_rdata_i;
    assign rd.rdata  = ram_rdata_i;
    assign wr.rvalid = (rsp_owner_q == OWN_WRITER);
    assign rd.rvalid = (rsp_owner_q == OWN_READER);

endmodule

`default_nettype wire

// File: verilog/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram (
    input  wire                                 clk_vpm,
    input  wire                                 en_i,
    input  wire                                 we_i,
    input  wire [vp_timing_pkg::ADDR_W-1:0]     addr_i,
    input  wire vp_pixel_pkg::rgb888_t          wdata_i,
    output vp_pixel_pkg::rgb888_t               rdata_o
);
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    // Two banks of one cropped line each, bank is addr_i MSB
    rgb888_t mem_q [RAM_DEPTH];

    // Single port, read data registered
    always_ff @(posedge clk_vpm) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];  // Holds until the next read
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/line_replay.sv
`timescale 1ns/1ps
`default_nettype none

module line_replay (
    input  wire                         clk_vpm,
    input  wire                         arst_n_i,
    input  wire                         line_done_i,
    input  wire                         bank_i,
    line_mem_if.requester               mem,
    output logic                        pix_valid_o,
    output vp_pixel_pkg::rgb888_t       pix_o
);
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    replay_state_e        state_q;
    logic                 bank_q;     // Bank being replayed
    logic [COL_W-1:0]     col_q;      // Next column to read
    logic                 last_q;     // Final column of the pass granted
    logic                 req_q;
    logic                 emit2_q;    // Second copy of the current pixel
    logic [OUT_CNT_W-1:0] hold_q;     // Gap between passes
    rgb888_t              pix_q;

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;          // Read only
    assign mem.addr  = {bank_q, col_q};
    assign mem.wdata = '0;

    // First copy straight from the RAM, second from the holding register
    assign pix_valid_o = mem.rvalid | emit2_q;
    assign pix_o       = mem.rvalid ? mem.rdata : pix_q;

    // --------------------------------------------------
    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RP_IDLE;
            bank_q  <= 1'b0;
            col_q   <= '0;
            last_q  <= 1'b0;
            req_q   <= 1'b0;
            emit2_q <= 1'b0;
            hold_q  <= '0;
        end else begin
            emit2_q <= mem.rvalid;
            if (hold_q != '0) hold_q <= hold_q - 1'b1;

            // Request drops once taken, writer may delay it
            if (mem.gnt) begin
                req_q  <= 1'b0;
                last_q <= (col_q == COL_W'(CROP_W - 1));
                col_q  <= (col_q == COL_W'(CROP_W - 1)) ? '0 : col_q + 1'b1;
            end

            case (state_q)
                RP_IDLE: begin
                    if (line_done_i) begin
                        bank_q  <= bank_i;
                        col_q   <= '0;
                        last_q  <= 1'b0;
                        req_q   <= 1'b1;
                        state_q <= RP_PASS0;
                    end
                end
                RP_PASS0: begin
                    if (mem.rvalid) begin
                        if (!last_q) begin
                            req_q <= 1'b1;  // Seen during the second copy
                        end else begin
                            // Leave room for the pad pixels of this output line
                            state_q <= RP_PASS1;
                            last_q  <= 1'b0;
                            hold_q  <= OUT_CNT_W'(PAD_N);
                        end
                    end
                end
                RP_PASS1: begin
                    if (hold_q == OUT_CNT_W'(1)) req_q <= 1'b1;  // Restart at column 0
                    if (mem.rvalid) begin
                        if (!last_q) begin
                            req_q <= 1'b1;
                        end else begin
                            state_q <= RP_IDLE;  // Line emitted twice
                            last_q  <= 1'b0;
                        end
                    end
                end
                default: state_q <= RP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_vpm) begin
        if (mem.rvalid) pix_q <= mem.rdata;
    end

endmodule

`default_nettype wire

// File: verilog/blank_fill.sv
`timescale 1ns/1ps
`default_nettype none

module blank_fill (
    input  wire                         clk_vpm,
    input  wire                         arst_n_i,
    input  wire                         pix_valid_i,
    input  wire vp_pixel_pkg::rgb888_t  pix_i,
    input  wire                         vs_i,
    output logic                        de_o,
    output logic                        vs_o,
    output vp_pixel_pkg::rgb565_t       data_o
);
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    logic [OUT_CNT_W-1:0] cnt_q;    // Position in the output line
    logic                 padding;  // Past the scaled pixels
    rgb888_t              pix_sel;

    assign padding = (cnt_q >= OUT_CNT_W'(2 * CROP_W));
    assign pix_sel = padding ? FILL_PIXEL : pix_i;

    // --------------------------------------------------
    // Line position, strobes during padding are not expected
    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
            de_o  <= 1'b0;
            vs_o  <= 1'b0;
        end else begin
            vs_o <= vs_i;  // One cycle lag
            de_o <= padding | pix_valid_i;
            if (padding) begin
                cnt_q <= (cnt_q == OUT_CNT_W'(OUT_H - 1)) ? '0 : cnt_q + 1'b1;
            end else if (pix_valid_i) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Drop the low bits back to RGB565
    always_ff @(posedge clk_vpm) begin
        if (padding || pix_valid_i) begin
            data_o <= {pix_sel.r[7:3], pix_sel.g[7:2], pix_sel.b[7:3]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/vp_top.sv
`timescale 1ns/1ps
`default_nettype none

module vp_top (
    input  wire                         clk_vpm,
    input  wire                         arst_n_i,
    input  wire                         vi_vs_i,
    input  wire                         vi_de_i,
    input  wire vp_pixel_pkg::rgb565_t  vi_data_i,
    output wire                         vp_vs_o,
    output wire                         vp_de_o,
    output wire vp_pixel_pkg::rgb565_t  vp_data_o
);
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    logic              line_done;   // Row stored, start replay
    logic              done_bank;
    logic              ram_en;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    rgb888_t           ram_wdata;
    rgb888_t           ram_rdata;
    logic              pix_valid;   // Upscaled pixel strobe
    rgb888_t           pix;

    line_mem_if wr_mem ();          // Crop writer
    line_mem_if rd_mem ();          // Replay reader

    // --------------------------------------------------
    video_crop u_crop (
        .clk_vpm     (clk_vpm),
        .arst_n_i    (arst_n_i),
        .vs_i        (vi_vs_i),
        .de_i        (vi_de_i),
        .data_i      (vi_data_i),
        .mem         (wr_mem.requester),
        .line_done_o (line_done),
        .bank_o      (done_bank)
    );

    mem_arbiter u_arb (
        .clk_vpm     (clk_vpm),
        .arst_n_i    (arst_n_i),
        .wr          (wr_mem.arbiter),
        .rd          (rd_mem.arbiter),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    line_ram u_ram (
        .clk_vpm (clk_vpm),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    line_replay u_replay (
        .clk_vpm     (clk_vpm),
        .arst_n_i    (arst_n_i),
        .line_done_i (line_done),
        .bank_i      (done_bank),
        .mem         (rd_mem.requester),
        .pix_valid_o (pix_valid),
        .pix_o       (pix)
    );

    blank_fill u_fill (
        .clk_vpm     (clk_vpm),
        .arst_n_i    (arst_n_i),
        .pix_valid_i (pix_valid),
        .pix_i       (pix),
        .vs_i        (vi_vs_i),
        .de_o        (vp_de_o),
        .vs_o        (vp_vs_o),
        .data_o      (vp_data_o)
    );

endmodule

`default_nettype wire

// File: verification/vp_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module vp_top_assert (
    input wire clk_vpm,
    input wire arst_n_i,
    input wire wr_req_i,
    input wire wr_gnt_i,
    input wire rd_gnt_i,
    input wire vp_de_i
);

    logic replay_seen_q;  // Reader granted at least once since reset

    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i)     replay_seen_q <= 1'b0;
        else if (rd_gnt_i) replay_seen_q <= 1'b1;
    end

    // --------------------------------------------------
    // Arbiter
    property p_one_grant;
        @(posedge clk_vpm) disable iff (!arst_n_i)
            !(wr_gnt_i && rd_gnt_i);
    endproperty

    property p_writer_never_waits;  // Fixed priority
        @(posedge clk_vpm) disable iff (!arst_n_i)
            wr_req_i |-> wr_gnt_i;
    endproperty

    // --------------------------------------------------
    // Output quiet from reset until the first replay read
    property p_de_low_after_reset;
        @(posedge clk_vpm) disable iff (!arst_n_i)
            !replay_seen_q |-> !vp_de_i;
    endproperty

    a_one_grant:          assert property (p_one_grant)          else $error("Both grants high");
    a_writer_never_waits: assert property (p_writer_never_waits) else $error("Writer not granted");
    a_de_low_after_reset: assert property (p_de_low_after_reset)
        else $error("vp_de_o high before any replay");

endmodule

bind vp_top vp_top_assert u_assert (
    .clk_vpm  (clk_vpm),
    .arst_n_i (arst_n_i),
    .wr_req_i (wr_mem.req),
    .wr_gnt_i (wr_mem.gnt),
    .rd_gnt_i (rd_mem.gnt),
    .vp_de_i  (vp_de_o)
);

`default_nettype wire

// File: verification/tb_vp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vp_top;
    import vp_timing_pkg::*;
    import vp_pixel_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;   // Inputs change after the edge
    localparam int RESET_CYCLES = 8;
    localparam int N_FRAMES     = 3;
    localparam int LINE_BLANK   = 40;
    localparam int MIN_BLANK    = 32;   // Tightest gap the replay keeps up with
    localparam int FRAME_LEAD   = 4;    // Idle cycles after vs
    localparam int FRAME_CYCLES = 1 + FRAME_LEAD + V_DISP * (H_DISP + LINE_BLANK);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_FRAMES * FRAME_CYCLES + 200;

    logic    clk_vpm;
    logic    arst_n_i;
    logic    vi_vs_i;
    logic    vi_de_i;
    rgb565_t vi_data_i;
    wire     vp_vs_o;
    wire     vp_de_o;
    rgb565_t vp_data_o;

    rgb565_t     expect_q[$];     // Reference output stream
    rgb565_t     line_q[$];       // Cropped pixels of the current input line
    rgb565_t     exp_pix;
    logic [31:0] rnd_state;
    logic        vs_dly;          // vi_vs_i one cycle late
    int          cycle_cnt = 0;

    vp_top i_dut (
        .clk_vpm   (clk_vpm),
        .arst_n_i  (arst_n_i),
        .vi_vs_i   (vi_vs_i),
        .vi_de_i   (vi_de_i),
        .vi_data_i (vi_data_i),
        .vp_vs_o   (vp_vs_o),
        .vp_de_o   (vp_de_o),
        .vp_data_o (vp_data_o)
    );

    initial begin
        clk_vpm = 1'b0;
        forever #(CLK_PERIOD / 2) clk_vpm = ~clk_vpm;
    end

    // --------------------------------------------------
    // Helpers
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_cycle;
        @(posedge clk_vpm);
        #DRIVE_DLY;
    endtask

    // One input line, then the reference output for it
    task automatic drive_line(input int y, input int blank);
        bit in_rows;
        in_rows = (y >= START_Y) && (y < END_Y);
        for (int x = 0; x < H_DISP; x++) begin
            rnd_state = xorshift32(rnd_state);
            vi_de_i   = 1'b1;
            vi_data_i = rnd_state[15:0];
            if (in_rows && x >= START_X && x < END_X) line_q.push_back(vi_data_i);
            next_cycle();
        end
        vi_de_i   = 1'b0;
        vi_data_i = '0;
        if (in_rows) begin
            for (int pass = 0; pass < 2; pass++) begin  // Line shown twice
                foreach (line_q[i]) begin
                    expect_q.push_back(line_q[i]);      // Pixel shown twice
                    expect_q.push_back(line_q[i]);
                end
                repeat (OUT_H - 2 * CROP_W) expect_q.push_back('0);  // Black pad
            end
        end
        line_q.delete();
        repeat (blank) next_cycle();
    endtask

    task automatic drive_frame(input int blank);
        vi_vs_i = 1'b1;
        next_cycle();
        vi_vs_i = 1'b0;
        repeat (FRAME_LEAD) next_cycle();
        for (int y = 0; y < V_DISP; y++) drive_line(y, blank);
    endtask

    // --------------------------------------------------
    // Checks, sampled away from the rising edge
    always @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) vs_dly <= 1'b0;
        else           vs_dly <= vi_vs_i;
    end

    always @(negedge clk_vpm) begin
        if (arst_n_i) begin
            assert (vp_vs_o === vs_dly) else
                report_fail($sformatf("FAILED %0t vp_vs_o got %b expected %b",
                                      $time, vp_vs_o, vs_dly));
            if (vp_de_o) begin
                assert (expect_q.size() > 0) else
                    report_fail($sformatf("Output pixel at %0t with none expected", $time));
                exp_pix = expect_q.pop_front();
                assert (vp_data_o === exp_pix) else
                    report_fail($sformatf("FAILED %0t vp_data_o got %h expected %h",
                                          $time, vp_data_o, exp_pix));
            end
        end
    end

    // Run limit
    always @(posedge clk_vpm) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_fail($sformatf("Timeout after %0d cycles, %0d pixels still expected",
                                  cycle_cnt, expect_q.size()));
        end
    end

    // --------------------------------------------------
    // Stimulus
    initial begin
        arst_n_i  = 1'b0;
        vi_vs_i   = 1'b0;
        vi_de_i   = 1'b0;
        vi_data_i = '0;
        rnd_state = 32'h32a7;

        repeat (RESET_CYCLES) @(posedge clk_vpm);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        repeat (4) next_cycle();

        drive_frame(LINE_BLANK);
        drive_frame(LINE_BLANK);
        drive_frame(MIN_BLANK);    // Replay runs close to the next write

        while (expect_q.size() != 0) @(posedge clk_vpm);
        repeat (2 * OUT_H) next_cycle();  // Any extra pixel trips the checker

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/vp_timing_pkg.sv
verilog/vp_pixel_pkg.sv
verilog/line_mem_if.sv
verilog/video_crop.sv
verilog/mem_arbiter.sv
verilog/line_ram.sv
verilog/line_replay.sv
verilog/blank_fill.sv
verilog/vp_top.sv
verification/vp_top_assert.sv
verification/tb_vp_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the video path testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_vp_top \
    -o sim_vp_top

./obj_dir/sim_vp_top | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
